//--- include/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// ---------------------------------------------------------------------------
// APB port
// ---------------------------------------------------------------------------
`define SOC_APB_ADDR_W   12     // Byte address, bit 8 picks the block
`define SOC_APB_DATA_W   32     // Also the register and SRAM word width

// ---------------------------------------------------------------------------
// Mailbox storage
// ---------------------------------------------------------------------------
`define SOC_MBOX_DEPTH   64     // Words
`define SOC_MBOX_ADDR_W  6      // Word address into the SRAM

// Generic wires toward the SoC
`define SOC_GENERIC_W    32

`endif

//--- verilog/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Register opcodes carried on the internal bus
    // Bit 7 holds the block select, bits 6:0 the byte offset inside the block
    typedef enum logic [7:0] {
        FUSE_DONE   = 8'h00,
        BOOT_STATUS = 8'h04,
        GENERIC_IN  = 8'h08,
        GENERIC_OUT = 8'h0C,
        LOCK        = 8'h80,    // Mailbox block from here on
        CMD         = 8'h84,
        DLEN        = 8'h88,
        DATAIN      = 8'h8C,
        DATAOUT     = 8'h90,
        EXECUTE     = 8'h94,
        STATUS      = 8'h98
    } reg_addr_e;

    typedef enum logic [1:0] {
        MBOX_IDLE = 2'd0,
        MBOX_CMD  = 2'd1,       // Lock held, sender filling the message
        MBOX_EXEC = 2'd2        // Message handed over, data-out draining
    } mbox_state_e;

    typedef enum logic [1:0] {
        BOOT_FUSE = 2'd0,
        BOOT_FW   = 2'd1,
        BOOT_RT   = 2'd2
    } boot_state_e;

endpackage

`default_nettype wire

//--- verilog/reg_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

// One register access from the APB bridge to a register block
interface reg_bus_if;
    import soc_pkg::*;

    logic                       req;    // Held until ready
    logic                       write;
    reg_addr_e                  addr;
    logic [`SOC_APB_DATA_W-1:0] wdata;
    logic [`SOC_APB_DATA_W-1:0] rdata;  // Valid with ready
    logic                       ready;
    logic                       err;    // Valid with ready

    modport initiator (
        output req, write, addr, wdata,
        input  rdata, ready, err
    );

    modport target (
        input  req, write, addr, wdata,
        output rdata, ready, err
    );

endinterface

`default_nettype wire

//--- verilog/soc_apb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_apb_bridge (
    input  logic                       clk,
    input  logic                       rst_i,

    input  logic [`SOC_APB_ADDR_W-1:0] paddr_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [`SOC_APB_DATA_W-1:0] pwdata_i,
    output logic                       pready_o,
    output logic [`SOC_APB_DATA_W-1:0] prdata_o,
    output logic                       pslverr_o,

    reg_bus_if.initiator               ifc_bus,
    reg_bus_if.initiator               mbox_bus
);
    import soc_pkg::*;

    logic       setup_ph;
    logic       access_ph;
    logic [7:0] op_d;
    logic       hit_d;
    logic       hit_q;          // Decode result captured in setup
    logic       blk_q;          // 1 = mailbox
    reg_addr_e  op_q;

    // Offsets that exist in the selected block
    function automatic logic is_mapped(input logic [7:0] op);
        case (op)
            FUSE_DONE, BOOT_STATUS, GENERIC_IN, GENERIC_OUT: return 1'b1;
            LOCK, CMD, DLEN, DATAIN, DATAOUT, EXECUTE, STATUS: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    assign setup_ph  = psel_i & ~penable_i;
    assign access_ph = psel_i & penable_i;

    // Block bit folded on top of the 7-bit offset
    assign op_d  = {paddr_i[8], paddr_i[6:0]};
    assign hit_d = (paddr_i[`SOC_APB_ADDR_W-1:9] == '0) && !paddr_i[7] && is_mapped(op_d);

    // ------------------------------------------------------------------------
    // Address decode, registered during the setup phase
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hit_q <= 1'b0;
        end else if (setup_ph) begin
            hit_q <= hit_d;
        end
    end

    always_ff @(posedge clk) begin
        if (setup_ph) begin
            blk_q <= paddr_i[8];
            op_q  <= reg_addr_e'(op_d);
        end
    end

    // Request held for the whole access phase, APB keeps it stable
    assign ifc_bus.req    = access_ph & hit_q & ~blk_q;
    assign ifc_bus.write  = pwrite_i;
    assign ifc_bus.addr   = op_q;
    assign ifc_bus.wdata  = pwdata_i;

    assign mbox_bus.req   = access_ph & hit_q & blk_q;
    assign mbox_bus.write = pwrite_i;
    assign mbox_bus.addr  = op_q;
    assign mbox_bus.wdata = pwdata_i;

    // ------------------------------------------------------------------------
    // Response back to the APB master
    // ------------------------------------------------------------------------
    always_comb begin
        pready_o  = 1'b0;
        pslverr_o = 1'b0;
        prdata_o  = '0;
        if (access_ph) begin
            if (!hit_q) begin
                pready_o  = 1'b1;   // Unmapped, answered here
                pslverr_o = 1'b1;
            end else if (blk_q) begin
                pready_o  = mbox_bus.ready;
                pslverr_o = mbox_bus.ready & mbox_bus.err;
                if (mbox_bus.ready && !pwrite_i) prdata_o = mbox_bus.rdata;
            end else begin
                pready_o  = ifc_bus.ready;
                pslverr_o = ifc_bus.ready & ifc_bus.err;
                if (ifc_bus.ready && !pwrite_i) prdata_o = ifc_bus.rdata;
            end
        end
    end

    // Read data from either target must be clean when it is handed out
    prdata_known_a: assert property (@(posedge clk) disable iff (rst_i)
        (pready_o && !pwrite_i) |-> !$isunknown(prdata_o))
        else $error("prdata_o unknown on a completed APB read");

endmodule

`default_nettype wire

//--- verilog/soc_ifc_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_ifc_regs (
    input  logic                     clk,
    input  logic                     rst_i,
    reg_bus_if.target                bus,
    input  soc_pkg::boot_state_e     boot_state_i,
    output logic                     fuse_done_o,
    input  logic [`SOC_GENERIC_W-1:0] generic_input_wires_i,
    output logic [`SOC_GENERIC_W-1:0] generic_output_wires_o
);
    import soc_pkg::*;

    logic                      wr_acc;
    logic [`SOC_GENERIC_W-1:0] gen_out_q;
    logic                      fuse_done_q;

    assign wr_acc = bus.req & bus.write;

    // Every access finishes in the cycle it arrives
    assign bus.ready = bus.req;
    assign bus.err   = 1'b0;

    always_comb begin
        case (bus.addr)
            BOOT_STATUS: bus.rdata = `SOC_APB_DATA_W'(boot_state_i);
            GENERIC_IN:  bus.rdata = `SOC_APB_DATA_W'(generic_input_wires_i);
            GENERIC_OUT: bus.rdata = `SOC_APB_DATA_W'(gen_out_q);
            default:     bus.rdata = '0;    // FUSE_DONE is write-only
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            gen_out_q   <= '0;
            fuse_done_q <= 1'b0;
        end else begin
            fuse_done_q <= wr_acc && (bus.addr == FUSE_DONE) && bus.wdata[0];
            if (wr_acc && (bus.addr == GENERIC_OUT)) begin
                gen_out_q <= bus.wdata[`SOC_GENERIC_W-1:0];
            end
        end
    end

    assign fuse_done_o            = fuse_done_q;    // One cycle, bus req is one cycle
    assign generic_output_wires_o = gen_out_q;

endmodule

`default_nettype wire

//--- verilog/boot_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module boot_fsm (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 fuse_done_i,
    input  logic                 flow_done_i,
    output soc_pkg::boot_state_e boot_state_o,
    output logic                 ready_for_fuses_o,
    output logic                 ready_for_fw_push_o,
    output logic                 ready_for_runtime_o
);
    import soc_pkg::*;

    boot_state_e state_q;
    boot_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            BOOT_FUSE: if (fuse_done_i) state_d = BOOT_FW;
            BOOT_FW:   if (flow_done_i) state_d = BOOT_RT;  // First mailbox flow
            default:   state_d = state_q;                   // Runtime is final
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= BOOT_FUSE;
        end else begin
            state_q <= state_d;
        end
    end

    assign boot_state_o        = state_q;
    assign ready_for_fuses_o   = (state_q == BOOT_FUSE);
    assign ready_for_fw_push_o = (state_q == BOOT_FW);
    assign ready_for_runtime_o = (state_q == BOOT_RT);

    ready_onehot_a: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0({ready_for_fuses_o, ready_for_fw_push_o, ready_for_runtime_o}))
        else $error("More than one boot ready output high");

endmodule

`default_nettype wire

//--- verilog/mbox_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module mbox_ctrl (
    input  logic                        clk,
    input  logic                        rst_i,
    reg_bus_if.target                   bus,

    output logic                        mbox_sram_cs_o,
    output logic                        mbox_sram_we_o,
    output logic [`SOC_MBOX_ADDR_W-1:0] mbox_sram_addr_o,
    output logic [`SOC_APB_DATA_W-1:0]  mbox_sram_wdata_o,
    input  logic [`SOC_APB_DATA_W-1:0]  mbox_sram_rdata_i,

    output logic                        mailbox_data_avail_o,
    output logic                        flow_done_o
);
    import soc_pkg::*;

    mbox_state_e                 state_q;
    logic [`SOC_MBOX_ADDR_W:0]   wr_ptr_q;      // One extra bit to reach DEPTH
    logic [`SOC_MBOX_ADDR_W-1:0] rd_ptr_q;
    logic [`SOC_APB_DATA_W-1:0]  cmd_q;
    logic [`SOC_APB_DATA_W-1:0]  dlen_q;
    logic                        avail_q;
    logic                        flow_done_q;
    logic                        rd_pend_q;     // DATAOUT wait state taken

    logic wr_acc, rd_acc;
    logic in_cmd, in_exec;
    logic wr_full;
    logic lock_grab;
    logic cmd_wr, dlen_wr;
    logic datain_ok;
    logic exec_go, exec_done;
    logic dout_rd, dout_issue;

    // ------------------------------------------------------------------------
    // Access decode
    // ------------------------------------------------------------------------
    assign wr_acc  = bus.req & bus.write;
    assign rd_acc  = bus.req & ~bus.write;
    assign in_cmd  = (state_q == MBOX_CMD);
    assign in_exec = (state_q == MBOX_EXEC);
    assign wr_full = (wr_ptr_q == (`SOC_MBOX_ADDR_W+1)'(`SOC_MBOX_DEPTH));

    assign lock_grab  = rd_acc && (bus.addr == LOCK) && (state_q == MBOX_IDLE);
    assign cmd_wr     = wr_acc && (bus.addr == CMD) && in_cmd;
    assign dlen_wr    = wr_acc && (bus.addr == DLEN) && in_cmd;
    assign datain_ok  = wr_acc && (bus.addr == DATAIN) && in_cmd && !wr_full;
    assign exec_go    = wr_acc && (bus.addr == EXECUTE) && in_cmd && bus.wdata[0];
    assign exec_done  = wr_acc && (bus.addr == EXECUTE) && in_exec && !bus.wdata[0];
    assign dout_rd    = rd_acc && (bus.addr == DATAOUT);
    assign dout_issue = dout_rd && in_exec && !rd_pend_q;

    // Every DATAOUT read takes one wait state, the SRAM word is back in the second
    assign bus.ready = bus.req & ~(dout_rd & ~rd_pend_q);

    always_comb begin
        case (bus.addr)
            CMD, DLEN: bus.err = bus.write & ~in_cmd;
            DATAIN:    bus.err = bus.write & (~in_cmd | wr_full);
            EXECUTE:   bus.err = bus.write & ~(exec_go | exec_done);
            DATAOUT:   bus.err = ~bus.write & ~in_exec;
            default:   bus.err = 1'b0;  // Read-only regs ignore writes
        endcase
    end

    always_comb begin
        case (bus.addr)
            LOCK:    bus.rdata = `SOC_APB_DATA_W'(state_q != MBOX_IDLE);
            CMD:     bus.rdata = cmd_q;
            DLEN:    bus.rdata = dlen_q;
            DATAOUT: bus.rdata = in_exec ? mbox_sram_rdata_i : '0;
            EXECUTE: bus.rdata = `SOC_APB_DATA_W'(in_exec);
            STATUS:  bus.rdata = `SOC_APB_DATA_W'(state_q);
            default: bus.rdata = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // SRAM port, write pointer for DATAIN, read pointer for DATAOUT
    // ------------------------------------------------------------------------
    assign mbox_sram_cs_o    = datain_ok | dout_issue;
    assign mbox_sram_we_o    = datain_ok;
    assign mbox_sram_addr_o  = datain_ok ? wr_ptr_q[`SOC_MBOX_ADDR_W-1:0] : rd_ptr_q;
    assign mbox_sram_wdata_o = bus.wdata;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= MBOX_IDLE;
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            cmd_q       <= '0;
            dlen_q      <= '0;
            avail_q     <= 1'b0;
            flow_done_q <= 1'b0;
            rd_pend_q   <= 1'b0;
        end else begin
            flow_done_q <= 1'b0;
            rd_pend_q   <= dout_rd & ~rd_pend_q;
            if (lock_grab) state_q <= MBOX_CMD;
            if (cmd_wr) cmd_q <= bus.wdata;
            if (dlen_wr) dlen_q <= bus.wdata;
            if (datain_ok) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (dout_issue) rd_ptr_q <= rd_ptr_q + 1'b1;
            if (exec_go) begin
                state_q  <= MBOX_EXEC;
                avail_q  <= 1'b1;
                rd_ptr_q <= '0;
            end
            if (exec_done) begin
                // Release, ready for the next sender
                state_q     <= MBOX_IDLE;
                wr_ptr_q    <= '0;
                rd_ptr_q    <= '0;
                avail_q     <= 1'b0;
                flow_done_q <= 1'b1;
            end
        end
    end

    assign mailbox_data_avail_o = avail_q;
    assign flow_done_o          = flow_done_q;

    sram_wr_in_cmd_a: assert property (@(posedge clk) disable iff (rst_i)
        (mbox_sram_cs_o && mbox_sram_we_o) |-> (state_q == MBOX_CMD))
        else $error("Mailbox SRAM written outside MBOX_CMD");

endmodule

`default_nettype wire

//--- verilog/cptra_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module cptra_soc_top (
    input  logic                        clk,
    input  logic                        rst_i,

    // APB slave
    input  logic [`SOC_APB_ADDR_W-1:0]  paddr_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [`SOC_APB_DATA_W-1:0]  pwdata_i,
    output logic                        pready_o,
    output logic [`SOC_APB_DATA_W-1:0]  prdata_o,
    output logic                        pslverr_o,

    // Mailbox SRAM
    output logic                        mbox_sram_cs_o,
    output logic                        mbox_sram_we_o,
    output logic [`SOC_MBOX_ADDR_W-1:0] mbox_sram_addr_o,
    output logic [`SOC_APB_DATA_W-1:0]  mbox_sram_wdata_o,
    input  logic [`SOC_APB_DATA_W-1:0]  mbox_sram_rdata_i,

    output logic                        ready_for_fuses_o,
    output logic                        ready_for_fw_push_o,
    output logic                        ready_for_runtime_o,
    output logic                        mailbox_data_avail_o,
    output logic                        mailbox_flow_done_o,

    input  logic [`SOC_GENERIC_W-1:0]   generic_input_wires_i,
    output logic [`SOC_GENERIC_W-1:0]   generic_output_wires_o
);
    import soc_pkg::*;

    logic        fuse_done;
    logic        flow_done;
    boot_state_e boot_state;

    reg_bus_if ifc_bus ();
    reg_bus_if mbox_bus ();

    soc_apb_bridge u_bridge (
        .clk       (clk),
        .rst_i     (rst_i),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .pready_o  (pready_o),
        .prdata_o  (prdata_o),
        .pslverr_o (pslverr_o),
        .ifc_bus   (ifc_bus),
        .mbox_bus  (mbox_bus)
    );

    soc_ifc_regs u_ifc_regs (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .bus                    (ifc_bus),
        .boot_state_i           (boot_state),
        .fuse_done_o            (fuse_done),
        .generic_input_wires_i  (generic_input_wires_i),
        .generic_output_wires_o (generic_output_wires_o)
    );

    boot_fsm u_boot_fsm (
        .clk                 (clk),
        .rst_i               (rst_i),
        .fuse_done_i         (fuse_done),
        .flow_done_i         (flow_done),
        .boot_state_o        (boot_state),
        .ready_for_fuses_o   (ready_for_fuses_o),
        .ready_for_fw_push_o (ready_for_fw_push_o),
        .ready_for_runtime_o (ready_for_runtime_o)
    );

    mbox_ctrl u_mbox (
        .clk                  (clk),
        .rst_i                (rst_i),
        .bus                  (mbox_bus),
        .mbox_sram_cs_o       (mbox_sram_cs_o),
        .mbox_sram_we_o       (mbox_sram_we_o),
        .mbox_sram_addr_o     (mbox_sram_addr_o),
        .mbox_sram_wdata_o    (mbox_sram_wdata_o),
        .mbox_sram_rdata_i    (mbox_sram_rdata_i),
        .mailbox_data_avail_o (mailbox_data_avail_o),
        .flow_done_o          (flow_done)
    );

    assign mailbox_flow_done_o = flow_done;     // Same pulse that ends BOOT_FW

endmodule

`default_nettype wire

//--- verif/soc_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_checker (
    input  logic                       clk,
    input  logic                       rst_i,

    // APB side of the DUT
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [`SOC_APB_ADDR_W-1:0] paddr_i,
    input  logic                       pready_i,
    input  logic [`SOC_APB_DATA_W-1:0] prdata_i,
    input  logic                       pslverr_i,

    // Boot and mailbox status
    input  logic                       fuses_i,
    input  logic                       fw_push_i,
    input  logic                       runtime_i,
    input  logic                       data_avail_i,
    input  logic                       flow_done_i,
    input  logic [`SOC_GENERIC_W-1:0]  generic_out_i,

    // Expected values handed over by tb_top
    input  int                         test_num_i,
    input  logic [`SOC_APB_DATA_W-1:0] exp_data_i,
    input  logic                       exp_err_i,
    input  logic                       chk_req_i,
    input  logic [7:0]                 chk_kind_i,     // S status word, G generic outputs
    input  logic [31:0]                chk_val_i,
    input  logic                       test_done_i,

    output int                         err_count_o,
    output int                         check_count_o
);

    // Mailbox block, offset 0x10
    localparam logic [`SOC_APB_ADDR_W-1:0] DATAOUT_ADDR = 'h110;

    int errors      = 0;
    int checks      = 0;
    int test_errs   = 0;
    int test_checks = 0;
    int flow_cnt    = 0;    // flow_done pulses since reset
    int waits       = 0;    // Access cycles without pready

    assign err_count_o   = errors;
    assign check_count_o = checks;

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("error at %0t: test %0d %s is 0x%h, expected 0x%h",
                     $time, test_num_i, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // Everything sampled on the rising edge, values settled since the last one
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_i) begin
            flow_cnt = 0;
            waits    = 0;
        end else begin
            if (psel_i && penable_i && pready_i) begin
                // DATAOUT reads take one wait state, every other access none
                compare(32'(waits), (!pwrite_i && paddr_i == DATAOUT_ADDR) ? 32'd1 : 32'd0,
                        $sformatf("wait states at 0x%h", paddr_i));
                waits = 0;
                compare({31'd0, pslverr_i}, {31'd0, exp_err_i},
                        $sformatf("pslverr at 0x%h", paddr_i));
                if (!pwrite_i) begin
                    compare(prdata_i, exp_data_i, $sformatf("prdata at 0x%h", paddr_i));
                end
            end else if (psel_i && penable_i) begin
                waits++;
            end

            if (chk_req_i) begin
                // Status word is flow count in 7:4, then avail, runtime, fw_push, fuses
                if (chk_kind_i == "S") begin
                    compare({24'd0, flow_cnt[3:0], data_avail_i, runtime_i, fw_push_i, fuses_i},
                            chk_val_i, "status word");
                end else begin
                    compare(32'(generic_out_i), chk_val_i, "generic_output_wires_o");
                end
            end

            if (flow_done_i) flow_cnt++;

            if (test_done_i) begin
                $display("test %0d: %0d checks, %0d errors, %s", test_num_i, test_checks,
                         test_errs, (test_errs == 0) ? "passed" : "failed");
                test_errs   = 0;
                test_checks = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module tb_top;

    localparam string STIM_FILE = "verif/mbox_stimulus.txt";

    logic                        clk;
    logic                        rst_i;
    logic [`SOC_APB_ADDR_W-1:0]  paddr;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`SOC_APB_DATA_W-1:0]  pwdata;
    logic                        pready;
    logic [`SOC_APB_DATA_W-1:0]  prdata;
    logic                        pslverr;
    logic                        sram_cs;
    logic                        sram_we;
    logic [`SOC_MBOX_ADDR_W-1:0] sram_addr;
    logic [`SOC_APB_DATA_W-1:0]  sram_wdata;
    logic [`SOC_APB_DATA_W-1:0]  sram_rdata;
    logic                        rdy_fuses;
    logic                        rdy_fw;
    logic                        rdy_rt;
    logic                        data_avail;
    logic                        flow_done;
    logic [`SOC_GENERIC_W-1:0]   gen_in;
    logic [`SOC_GENERIC_W-1:0]   gen_out;

    // Hand-over to the checker
    int                          test_num;
    logic [`SOC_APB_DATA_W-1:0]  exp_data;
    logic                        exp_err;
    logic                        chk_req;
    logic [7:0]                  chk_kind;
    logic [31:0]                 chk_val;
    logic                        test_done;
    int                          err_count;
    int                          check_count;

    // One entry per stimulus line
    int                          q_test[$];
    logic [7:0]                  q_op[$];
    logic [`SOC_APB_ADDR_W-1:0]  q_addr[$];
    logic [31:0]                 q_data[$];
    bit                          q_err[$];
    int                          q_rep[$];

    logic [`SOC_APB_DATA_W-1:0]  sram_mem [0:`SOC_MBOX_DEPTH-1];
    int                          cycle_cnt   = 0;
    int                          cycle_limit = 0;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    cptra_soc_top uut (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .paddr_i                (paddr),
        .psel_i                 (psel),
        .penable_i              (penable),
        .pwrite_i               (pwrite),
        .pwdata_i               (pwdata),
        .pready_o               (pready),
        .prdata_o               (prdata),
        .pslverr_o              (pslverr),
        .mbox_sram_cs_o         (sram_cs),
        .mbox_sram_we_o         (sram_we),
        .mbox_sram_addr_o       (sram_addr),
        .mbox_sram_wdata_o      (sram_wdata),
        .mbox_sram_rdata_i      (sram_rdata),
        .ready_for_fuses_o      (rdy_fuses),
        .ready_for_fw_push_o    (rdy_fw),
        .ready_for_runtime_o    (rdy_rt),
        .mailbox_data_avail_o   (data_avail),
        .mailbox_flow_done_o    (flow_done),
        .generic_input_wires_i  (gen_in),
        .generic_output_wires_o (gen_out)
    );

    soc_checker u_chk (
        .clk           (clk),
        .rst_i         (rst_i),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .paddr_i       (paddr),
        .pready_i      (pready),
        .prdata_i      (prdata),
        .pslverr_i     (pslverr),
        .fuses_i       (rdy_fuses),
        .fw_push_i     (rdy_fw),
        .runtime_i     (rdy_rt),
        .data_avail_i  (data_avail),
        .flow_done_i   (flow_done),
        .generic_out_i (gen_out),
        .test_num_i    (test_num),
        .exp_data_i    (exp_data),
        .exp_err_i     (exp_err),
        .chk_req_i     (chk_req),
        .chk_kind_i    (chk_kind),
        .chk_val_i     (chk_val),
        .test_done_i   (test_done),
        .err_count_o   (err_count),
        .check_count_o (check_count)
    );

    // ------------------------------------------------------------------------
    // Mailbox SRAM, data one cycle after a read
    // ------------------------------------------------------------------------
    initial begin
        for (int i = 0; i < `SOC_MBOX_DEPTH; i++) begin
            sram_mem[i] = 32'h5EED_0000 | 32'(i);
        end
    end

    always @(posedge clk) begin
        if (sram_cs) begin
            if (sram_we) sram_mem[sram_addr] <= sram_wdata;
            else         sram_rdata <= sram_mem[sram_addr];
        end
    end

    // Limit from the stimulus length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic load_stimulus(output logic ok);
        int         fd;
        int         n;
        int         t;
        int         e;
        int         r;
        int         total;
        logic [7:0] op;
        logic [`SOC_APB_ADDR_W-1:0] a;
        logic [31:0] d;
        string      line;
        ok    = 1'b1;
        total = 0;
        fd    = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open %s, no tests were run", STIM_FILE);
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %c %h %h %d %d", t, op, a, d, e, r);
                    if (n != 6 || !(op inside {"W", "R", "S", "G"}) || r < 1) begin
                        $display("Bad stimulus line: %s", line);
                        ok = 1'b0;
                    end else begin
                        q_test.push_back(t);
                        q_op.push_back(op);
                        q_addr.push_back(a);
                        q_data.push_back(d);
                        q_err.push_back(e != 0);
                        q_rep.push_back(r);
                        total += r;
                    end
                end
            end
            $fclose(fd);
            if (q_op.size() == 0) begin
                $display("Stimulus file %s holds no operations", STIM_FILE);
                ok = 1'b0;
            end
            cycle_limit = total * 8 + 100;
        end
    endtask

    // One APB transfer, then 0 to 3 idle cycles
    task automatic apb_transfer(input int num, input logic wr,
                                input logic [`SOC_APB_ADDR_W-1:0] addr,
                                input logic [31:0] val, input logic err);
        @(posedge clk);
        psel     <= 1'b1;
        penable  <= 1'b0;
        pwrite   <= wr;
        paddr    <= addr;
        pwdata   <= wr ? val : '0;
        test_num <= num;
        exp_data <= val;
        exp_err  <= err;
        @(posedge clk);
        penable  <= 1'b1;
        @(posedge clk);
        while (!pready) @(posedge clk);
        psel     <= 1'b0;
        penable  <= 1'b0;
        repeat ($urandom_range(3, 0)) @(posedge clk);
    endtask

    task automatic check_outputs(input int num, input logic [7:0] kind, input logic [31:0] val);
        @(posedge clk);
        test_num <= num;
        chk_req  <= 1'b1;
        chk_kind <= kind;
        chk_val  <= val;
        @(posedge clk);
        chk_req  <= 1'b0;
    endtask

    task automatic close_test(input int num);
        @(posedge clk);
        test_num  <= num;
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    task automatic run_line(input int i);
        int          k;
        logic [31:0] val;
        for (k = 0; k < q_rep[i]; k++) begin
            val = q_data[i] + 32'(k);   // Repeats step the data word
            if (q_op[i] == "S" || q_op[i] == "G") begin
                check_outputs(q_test[i], q_op[i], val);
            end else begin
                if (q_op[i] == "R" && q_addr[i] == 12'h008) val = gen_in;
                apb_transfer(q_test[i], q_op[i] == "W", q_addr[i], val, q_err[i]);
            end
        end
    endtask

    initial begin : main
        logic ok;
        void'($urandom(64));
        rst_i      = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        sram_rdata = '0;
        gen_in     = $urandom();        // Held for the whole run
        test_num   = 0;
        exp_data   = '0;
        exp_err    = 1'b0;
        chk_req    = 1'b0;
        chk_kind   = 8'd0;
        chk_val    = '0;
        test_done  = 1'b0;

        load_stimulus(ok);
        if (!ok) begin
            $display("Finished with errors");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            rst_i <= 1'b0;
            for (int i = 0; i < q_op.size(); i++) begin
                if (i > 0 && q_test[i] != q_test[i-1]) close_test(q_test[i-1]);
                run_line(i);
            end
            close_test(q_test[q_test.size()-1]);
            repeat (2) @(posedge clk);

            $display("%0d checks, %0d errors", check_count, err_count);
            if (err_count == 0 && check_count > 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verif/mbox_stimulus.txt
# test op addr data err rep; addr and data hex, rep repeats the line with data + 1 each time
# op W write, R read with expected data, S status word {flow count, avail, rt, fw, fuses}, G outputs
1 S 000 00000001 0 1
1 W 000 00000001 0 1   # FUSE_DONE
1 R 004 00000001 0 1   # BOOT_FW
1 R 000 00000000 0 1
1 S 000 00000002 0 1
2 W 00C 5A5AC3C3 0 1
2 G 000 5A5AC3C3 0 1
2 R 00C 5A5AC3C3 0 1
2 R 008 00000000 0 1   # GENERIC_IN, data taken from the held input
3 R 118 00000000 0 1
3 R 100 00000000 0 1   # Lock acquired
3 R 100 00000001 0 1
3 R 118 00000001 0 1
3 W 104 0000C0DE 0 1
3 W 108 00000010 0 1
3 W 10C A0000000 0 4
3 R 104 0000C0DE 0 1
3 R 108 00000010 0 1
3 W 114 00000001 0 1
3 S 000 0000000A 0 1
3 R 118 00000002 0 1
3 R 110 A0000000 0 4
3 W 114 00000000 0 1
4 S 000 00000014 0 1
4 R 004 00000002 0 1
5 W 10C DEADBEEF 1 1   # DATAIN while idle
5 R 110 00000000 1 1
5 R 200 00000000 1 1
5 W 020 00000000 1 1
5 R 118 00000000 0 1
5 S 000 00000014 0 1
5 R 100 00000000 0 1
5 W 10C 00000000 0 64
5 W 10C FFFFFFFF 1 1   # Past 64 words, word 0 must survive
5 R 110 00000000 1 1
5 W 114 00000000 1 1
5 W 114 00000001 0 1
5 R 110 00000000 0 3
5 W 114 00000000 0 1
5 S 000 00000024 0 1
6 R 118 00000000 0 1
6 R 100 00000000 0 1
6 R 118 00000001 0 1
6 W 104 0000BEEF 0 1
6 W 108 00000014 0 1
6 W 10C 12340000 0 5
6 W 114 00000001 0 1
6 R 118 00000002 0 1
6 S 000 0000002C 0 1
6 R 110 12340000 0 5
6 W 114 00000000 0 1
6 R 118 00000000 0 1
6 S 000 00000034 0 1
6 R 004 00000002 0 1

//--- sim.f
+incdir+include
verilog/soc_pkg.sv
verilog/reg_bus_if.sv
verilog/soc_apb_bridge.sv
verilog/soc_ifc_regs.sv
verilog/boot_fsm.sv
verilog/mbox_ctrl.sv
verilog/cptra_soc_top.sv
verif/soc_checker.sv
verif/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_top -f sim.f

out=$(./obj_dir/Vtb_top)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi
